// ==== hdl/isaPkg.sv ====
package isaPkg;

    // instruction word layout
    localparam int instrW  = 16;
    localparam int opHi    = 15;
    localparam int opLo    = 11;
    localparam int functHi = 1;
    localparam int imm5Hi  = 4;
    localparam int imm8Hi  = 7;

    typedef logic [instrW-1:0] instr_t;
    typedef logic [opHi-opLo:0] opcode_t;
    typedef logic [functHi:0] funct_t;

    // immediate arithmetic and logic
    localparam opcode_t opAddi  = 5'b01000;
    localparam opcode_t opSubi  = 5'b01001;
    localparam opcode_t opXori  = 5'b01010;
    localparam opcode_t opAndni = 5'b01011;

    // immediate shifts take their kind from the low two bits
    localparam opcode_t opRoli = 5'b10100;
    localparam opcode_t opSlli = 5'b10101;
    localparam opcode_t opRori = 5'b10110;
    localparam opcode_t opSrli = 5'b10111;

    // memory ops only need the address sum here
    localparam opcode_t opSt  = 5'b10000;
    localparam opcode_t opLd  = 5'b10001;
    localparam opcode_t opStu = 5'b10011;

    localparam opcode_t opSlbi    = 5'b10010;
    localparam opcode_t opLbi     = 5'b11000;
    localparam opcode_t opBtr     = 5'b11001;
    localparam opcode_t opShiftR  = 5'b11010;
    localparam opcode_t opArithR  = 5'b11011;

    localparam opcode_t opSeq = 5'b11100;
    localparam opcode_t opSlt = 5'b11101;
    localparam opcode_t opSle = 5'b11110;
    localparam opcode_t opSco = 5'b11111;

    // R-format arithmetic group
    localparam funct_t fnAdd  = 2'b00;
    localparam funct_t fnSub  = 2'b01;
    localparam funct_t fnXor  = 2'b10;
    localparam funct_t fnAndn = 2'b11;

endpackage

// ==== hdl/aluPkg.sv ====
package aluPkg;

    localparam int wordW     = 16;
    localparam int imm8W     = 8;
    localparam int shamtW    = 4;
    localparam int pipeDepth = 3;

    typedef logic [wordW-1:0] word_t;
    typedef logic [imm8W-1:0] imm8_t;
    typedef logic [shamtW-1:0] shamt_t;

    // where the stage 3 result comes from
    typedef enum logic [2:0] {
        srcAdd,
        srcXor,
        srcAndn,
        srcShift,
        srcFlag,
        srcLbi,
        srcSlbi,
        srcZero
    } resSrc_t;

    typedef logic [1:0] shiftOp_t;
    localparam shiftOp_t shRol = 2'b00;
    localparam shiftOp_t shSll = 2'b01;
    localparam shiftOp_t shRor = 2'b10;
    localparam shiftOp_t shSrl = 2'b11;

    typedef logic [1:0] flagOp_t;
    localparam flagOp_t flEq    = 2'b00;
    localparam flagOp_t flLt    = 2'b01;
    localparam flagOp_t flLe    = 2'b10;
    localparam flagOp_t flCarry = 2'b11;

endpackage

// ==== hdl/instrDecode.sv ====
`timescale 1ns/10ps

module instrDecode (
    input  logic              clk,
    input  logic              rstN,
    input  logic              inValid,
    input  isaPkg::instr_t    instr,
    input  aluPkg::word_t     rsData,
    input  aluPkg::word_t     rtData,
    output logic              d1Valid,
    output aluPkg::resSrc_t   d1Src,
    output logic              d1InvS,
    output logic              d1InvT,
    output logic              d1UseImm5,
    output logic              d1SignImm,
    output logic              d1UseImm8,
    output aluPkg::shiftOp_t  d1ShiftOp,
    output aluPkg::flagOp_t   d1FlagOp,
    output logic              d1IsBtr,
    output aluPkg::imm8_t     d1Imm,
    output aluPkg::word_t     d1Rs,
    output aluPkg::word_t     d1Rt
);
    import isaPkg::*;
    import aluPkg::*;

    opcode_t  opcode;
    funct_t   funct;
    resSrc_t  src;
    logic     invS;
    logic     invT;
    logic     useImm5;
    logic     signImm;
    logic     useImm8;
    logic     isBtr;
    shiftOp_t shiftOp;
    flagOp_t  flagOp;

    assign opcode = instr[opHi:opLo];
    assign funct  = instr[functHi:0];

    always_comb begin
        src     = srcZero;
        invS    = 1'b0;
        invT    = 1'b0;
        useImm5 = 1'b0;
        signImm = 1'b0;
        useImm8 = 1'b0;
        isBtr   = 1'b0;
        // immediate shifts and compares encode their kind in the low opcode bits
        shiftOp = opcode[1:0];
        flagOp  = opcode[1:0];
        case (opcode)
            opAddi, opSt, opLd, opStu: begin
                src     = srcAdd;
                useImm5 = 1'b1;
                signImm = 1'b1;
            end
            opSubi: begin
                src     = srcAdd;
                invS    = 1'b1;
                useImm5 = 1'b1;
                signImm = 1'b1;
            end
            opXori: begin
                src     = srcXor;
                useImm5 = 1'b1;
            end
            opAndni: begin
                src     = srcAndn;
                useImm5 = 1'b1;
            end
            opRoli, opSlli, opRori, opSrli: begin
                src     = srcShift;
                useImm5 = 1'b1;
            end
            opShiftR: begin
                src     = srcShift;
                shiftOp = funct;
            end
            opBtr: begin
                src   = srcShift;
                isBtr = 1'b1;
            end
            opArithR: begin
                case (funct)
                    fnAdd:   src = srcAdd;
                    fnSub: begin
                        src  = srcAdd;
                        invS = 1'b1;
                    end
                    fnXor:   src = srcXor;
                    fnAndn:  src = srcAndn;
                    default: src = srcZero;
                endcase
            end
            opSeq, opSlt, opSle: begin
                src  = srcFlag;
                invT = 1'b1;
            end
            // carry-out of the plain sum without inversion
            opSco: src = srcFlag;
            opLbi: begin
                src     = srcLbi;
                useImm8 = 1'b1;
            end
            opSlbi:  src = srcSlbi;
            default: src = srcZero;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            d1Valid <= 1'b0;
        end else begin
            d1Valid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            d1Src     <= src;
            d1InvS    <= invS;
            d1InvT    <= invT;
            d1UseImm5 <= useImm5;
            d1SignImm <= signImm;
            d1UseImm8 <= useImm8;
            d1ShiftOp <= shiftOp;
            d1FlagOp  <= flagOp;
            d1IsBtr   <= isBtr;
            d1Imm     <= instr[imm8Hi:0];
            d1Rs      <= rsData;
            d1Rt      <= rtData;
        end
    end

endmodule

// ==== hdl/operandSelect.sv ====
`timescale 1ns/10ps

module operandSelect (
    input  logic              clk,
    input  logic              rstN,
    input  logic              d1Valid,
    input  aluPkg::resSrc_t   d1Src,
    input  logic              d1InvS,
    input  logic              d1InvT,
    input  logic              d1UseImm5,
    input  logic              d1SignImm,
    input  logic              d1UseImm8,
    input  aluPkg::shiftOp_t  d1ShiftOp,
    input  aluPkg::flagOp_t   d1FlagOp,
    input  logic              d1IsBtr,
    input  aluPkg::imm8_t     d1Imm,
    input  aluPkg::word_t     d1Rs,
    input  aluPkg::word_t     d1Rt,
    output logic              o2Valid,
    output aluPkg::word_t     o2A,
    output aluPkg::word_t     o2B,
    output logic              o2Cin,
    output aluPkg::word_t     o2Rs,
    output aluPkg::imm8_t     o2Imm,
    output aluPkg::resSrc_t   o2Src,
    output aluPkg::shiftOp_t  o2ShiftOp,
    output aluPkg::flagOp_t   o2FlagOp,
    output logic              o2IsBtr
);
    import isaPkg::*;
    import aluPkg::*;

    logic [imm5Hi:0] imm5;
    word_t           imm5Ext;
    word_t           imm8Ext;
    word_t           aNext;
    word_t           bNext;

    assign imm5    = d1Imm[imm5Hi:0];
    assign imm5Ext = d1SignImm ? {{(wordW-imm5Hi-1){imm5[imm5Hi]}}, imm5}
                               : {{(wordW-imm5Hi-1){1'b0}}, imm5};
    // lbi value is formed here and passed through as b
    assign imm8Ext = {{(wordW-imm8Hi-1){d1Imm[imm8Hi]}}, d1Imm};

    assign aNext = d1InvS ? ~d1Rs : d1Rs;
    assign bNext = d1UseImm5 ? imm5Ext :
                   d1UseImm8 ? imm8Ext :
                   d1InvT    ? ~d1Rt   : d1Rt;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            o2Valid <= 1'b0;
        end else begin
            o2Valid <= d1Valid;
        end
    end

    always_ff @(posedge clk) begin
        if (d1Valid) begin
            o2A       <= aNext;
            o2B       <= bNext;
            // +1 completes the two's complement of the inverted side
            o2Cin     <= d1InvS | d1InvT;
            o2Rs      <= d1Rs;
            o2Imm     <= d1Imm;
            o2Src     <= d1Src;
            o2ShiftOp <= d1ShiftOp;
            o2FlagOp  <= d1FlagOp;
            o2IsBtr   <= d1IsBtr;
        end
    end

endmodule

// ==== hdl/shiftUnit.sv ====
`timescale 1ns/10ps

module shiftUnit (
    input  aluPkg::word_t    value,
    input  aluPkg::shamt_t   shamt,
    input  aluPkg::shiftOp_t shiftOp,
    input  logic             isBtr,
    output aluPkg::word_t    shifted
);
    import aluPkg::*;

    function automatic word_t reverseBits(input word_t v);
        word_t r;
        for (int i = 0; i < wordW; i++) begin
            r[i] = v[wordW-1-i];
        end
        return r;
    endfunction

    logic  doRotate;
    logic  doReverse;
    word_t preFlip;
    word_t barrel;

    always_comb begin
        case (shiftOp)
            shRol: begin
                doRotate  = 1'b1;
                doReverse = 1'b0;
            end
            shSll: begin
                doRotate  = 1'b0;
                doReverse = 1'b0;
            end
            shRor: begin
                doRotate  = 1'b1;
                doReverse = 1'b1;
            end
            shSrl: begin
                doRotate  = 1'b0;
                doReverse = 1'b1;
            end
            default: begin
                doRotate  = 1'b0;
                doReverse = 1'b0;
            end
        endcase
    end

    // right ops run through the left barrel on the mirrored word
    assign preFlip = doReverse ? reverseBits(value) : value;

    // one level per shamt bit, each moving by a power of two
    always_comb begin
        barrel = preFlip;
        for (int i = 0; i < shamtW; i++) begin
            if (shamt[i]) begin
                if (doRotate) begin
                    barrel = (barrel << (1 << i)) | (barrel >> (wordW - (1 << i)));
                end else begin
                    barrel = barrel << (1 << i);
                end
            end
        end
    end

    // btr bypasses the barrel entirely
    assign shifted = isBtr     ? reverseBits(value) :
                     doReverse ? reverseBits(barrel) : barrel;

endmodule

// ==== hdl/aluExecute.sv ====
`timescale 1ns/10ps

module aluExecute (
    input  logic              clk,
    input  logic              rstN,
    input  logic              o2Valid,
    input  aluPkg::word_t     o2A,
    input  aluPkg::word_t     o2B,
    input  logic              o2Cin,
    input  aluPkg::word_t     o2Rs,
    input  aluPkg::imm8_t     o2Imm,
    input  aluPkg::resSrc_t   o2Src,
    input  aluPkg::shiftOp_t  o2ShiftOp,
    input  aluPkg::flagOp_t   o2FlagOp,
    input  logic              o2IsBtr,
    output logic              outValid,
    output aluPkg::word_t     result
);
    import aluPkg::*;

    logic [wordW:0] sum;
    word_t          sumW;
    logic           carryOut;
    logic           zero;
    logic           neg;
    logic           flagBit;
    word_t          flagRes;
    word_t          slbiRes;
    word_t          shiftRes;
    word_t          nextResult;

    assign sum      = {1'b0, o2A} + {1'b0, o2B} + {{wordW{1'b0}}, o2Cin};
    assign sumW     = sum[wordW-1:0];
    assign carryOut = sum[wordW];

    // compares look at rs - rt
    assign zero = ~|sumW;
    assign neg  = sumW[wordW-1];

    always_comb begin
        case (o2FlagOp)
            flEq:    flagBit = zero;
            flLt:    flagBit = neg;
            flLe:    flagBit = neg | zero;
            flCarry: flagBit = carryOut;
            default: flagBit = 1'b0;
        endcase
    end

    assign flagRes = {{(wordW-1){1'b0}}, flagBit};
    assign slbiRes = {o2Rs[imm8W-1:0], o2Imm};

    shiftUnit shift0 (
        .value   (o2Rs),
        .shamt   (o2B[shamtW-1:0]),
        .shiftOp (o2ShiftOp),
        .isBtr   (o2IsBtr),
        .shifted (shiftRes)
    );

    always_comb begin
        case (o2Src)
            srcAdd:   nextResult = sumW;
            srcXor:   nextResult = o2A ^ o2B;
            srcAndn:  nextResult = o2A & ~o2B;
            srcShift: nextResult = shiftRes;
            srcFlag:  nextResult = flagRes;
            // b already holds the sign-extended imm8
            srcLbi:   nextResult = o2B;
            srcSlbi:  nextResult = slbiRes;
            default:  nextResult = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= o2Valid;
        end
    end

    always_ff @(posedge clk) begin
        if (o2Valid) begin
            result <= nextResult;
        end
    end

endmodule

// ==== hdl/executePipe.sv ====
`timescale 1ns/10ps

module executePipe (
    input  logic           clk,
    input  logic           rstN,
    input  logic           inValid,
    input  isaPkg::instr_t instr,
    input  aluPkg::word_t  rsData,
    input  aluPkg::word_t  rtData,
    output logic           outValid,
    output aluPkg::word_t  result
);
    import aluPkg::*;

    // stage 1 to stage 2
    logic     d1Valid;
    resSrc_t  d1Src;
    logic     d1InvS;
    logic     d1InvT;
    logic     d1UseImm5;
    logic     d1SignImm;
    logic     d1UseImm8;
    shiftOp_t d1ShiftOp;
    flagOp_t  d1FlagOp;
    logic     d1IsBtr;
    imm8_t    d1Imm;
    word_t    d1Rs;
    word_t    d1Rt;

    // stage 2 to stage 3
    logic     o2Valid;
    word_t    o2A;
    word_t    o2B;
    logic     o2Cin;
    word_t    o2Rs;
    imm8_t    o2Imm;
    resSrc_t  o2Src;
    shiftOp_t o2ShiftOp;
    flagOp_t  o2FlagOp;
    logic     o2IsBtr;

    instrDecode decode0 (
        .clk       (clk),
        .rstN      (rstN),
        .inValid   (inValid),
        .instr     (instr),
        .rsData    (rsData),
        .rtData    (rtData),
        .d1Valid   (d1Valid),
        .d1Src     (d1Src),
        .d1InvS    (d1InvS),
        .d1InvT    (d1InvT),
        .d1UseImm5 (d1UseImm5),
        .d1SignImm (d1SignImm),
        .d1UseImm8 (d1UseImm8),
        .d1ShiftOp (d1ShiftOp),
        .d1FlagOp  (d1FlagOp),
        .d1IsBtr   (d1IsBtr),
        .d1Imm     (d1Imm),
        .d1Rs      (d1Rs),
        .d1Rt      (d1Rt)
    );

    operandSelect operand0 (
        .clk       (clk),
        .rstN      (rstN),
        .d1Valid   (d1Valid),
        .d1Src     (d1Src),
        .d1InvS    (d1InvS),
        .d1InvT    (d1InvT),
        .d1UseImm5 (d1UseImm5),
        .d1SignImm (d1SignImm),
        .d1UseImm8 (d1UseImm8),
        .d1ShiftOp (d1ShiftOp),
        .d1FlagOp  (d1FlagOp),
        .d1IsBtr   (d1IsBtr),
        .d1Imm     (d1Imm),
        .d1Rs      (d1Rs),
        .d1Rt      (d1Rt),
        .o2Valid   (o2Valid),
        .o2A       (o2A),
        .o2B       (o2B),
        .o2Cin     (o2Cin),
        .o2Rs      (o2Rs),
        .o2Imm     (o2Imm),
        .o2Src     (o2Src),
        .o2ShiftOp (o2ShiftOp),
        .o2FlagOp  (o2FlagOp),
        .o2IsBtr   (o2IsBtr)
    );

    aluExecute execute0 (
        .clk       (clk),
        .rstN      (rstN),
        .o2Valid   (o2Valid),
        .o2A       (o2A),
        .o2B       (o2B),
        .o2Cin     (o2Cin),
        .o2Rs      (o2Rs),
        .o2Imm     (o2Imm),
        .o2Src     (o2Src),
        .o2ShiftOp (o2ShiftOp),
        .o2FlagOp  (o2FlagOp),
        .o2IsBtr   (o2IsBtr),
        .outValid  (outValid),
        .result    (result)
    );

endmodule

// ==== test/executePipe_props.sv ====
`timescale 1ns/10ps

module executePipeProps (
    input logic           clk,
    input logic           rstN,
    input logic           inValid,
    input isaPkg::instr_t instr,
    input logic           outValid,
    input aluPkg::word_t  result
);
    import isaPkg::*;
    import aluPkg::*;

    logic isCompare;

    assign isCompare = instr[opHi:opLo] inside {opSeq, opSlt, opSle, opSco};

    resetClearsValid: assert property (@(posedge clk) !rstN |=> !outValid)
        else $error("outValid high after a reset cycle");

    // every accepted input comes out exactly pipeDepth edges later
    validLatency: assert property (@(posedge clk) disable iff (!rstN)
        outValid == $past(inValid, pipeDepth))
        else $error("outValid does not follow inValid by the pipeline depth");

    flagShape: assert property (@(posedge clk) disable iff (!rstN)
        ($past(inValid, pipeDepth) && $past(isCompare, pipeDepth))
            |-> result[wordW-1:1] == '0)
        else $error("compare result has bits set above bit 0");

endmodule

bind executePipe executePipeProps props0 (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .instr    (instr),
    .outValid (outValid),
    .result   (result)
);

// ==== test/executePipeTb.sv ====
`timescale 1ns/10ps

module executePipeTb;
    import isaPkg::*;
    import aluPkg::*;

    localparam int clkPeriod   = 4;
    localparam int resetCycles = 5;
    localparam int numRandom   = 400;
    localparam int directedMax = 128;
    localparam int margin      = 50;
    // random section idles at most once per instruction
    localparam int runCycles   = resetCycles + directedMax + 2 * numRandom + pipeDepth + margin;
    localparam int timeoutNs   = runCycles * clkPeriod;

    logic        clk = 1'b0;
    logic        rstN;
    logic        inValid;
    instr_t      instr;
    word_t       rsData;
    word_t       rtData;
    logic        outValid;
    word_t       result;

    word_t       expQ[$];
    int          dueQ[$];
    int          cycle = 0;
    int          checked = 0;
    int          valueErrs = 0;
    int          timingErrs = 0;
    int          protoErrs = 0;
    word_t       expVal;
    int          dueCycle;
    logic [4:0]  pick;

    opcode_t opTable [0:19] = '{opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori,
        opSrli, opSt, opLd, opStu, opSlbi, opLbi, opBtr, opShiftR, opArithR, opSeq, opSlt,
        opSle, opSco};

    executePipe dut0 (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .instr    (instr),
        .rsData   (rsData),
        .rtData   (rtData),
        .outValid (outValid),
        .result   (result)
    );

    always #(clkPeriod / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic word_t reverseWord(input word_t v);
        word_t r;
        for (int i = 0; i < wordW; i++) begin
            r[i] = v[wordW-1-i];
        end
        return r;
    endfunction

    function automatic word_t shiftRef(input word_t v, input shiftOp_t kind, input shamt_t n);
        word_t r;
        case (kind)
            shRol:   r = (v << n) | (v >> (wordW - n));
            shSll:   r = v << n;
            shRor:   r = (v >> n) | (v << (wordW - n));
            default: r = v >> n;
        endcase
        return r;
    endfunction

    // expected result straight from the ISA rules
    function automatic word_t refResult(input instr_t ins, input word_t rs, input word_t rt);
        opcode_t     op;
        funct_t      fn;
        word_t       simm5;
        word_t       zimm5;
        word_t       diff;
        logic [16:0] wide;
        op    = ins[15:11];
        fn    = ins[1:0];
        simm5 = {{11{ins[4]}}, ins[4:0]};
        zimm5 = {11'b0, ins[4:0]};
        diff  = rs - rt;
        wide  = {1'b0, rs} + {1'b0, rt};
        case (op)
            opAddi, opSt, opLd, opStu: return rs + simm5;
            opSubi:   return simm5 - rs;
            opXori:   return rs ^ zimm5;
            opAndni:  return rs & ~zimm5;
            opRoli, opSlli, opRori, opSrli: return shiftRef(rs, op[1:0], ins[3:0]);
            opShiftR: return shiftRef(rs, fn, rt[3:0]);
            opBtr:    return reverseWord(rs);
            opArithR: begin
                case (fn)
                    fnAdd:   return rs + rt;
                    fnSub:   return rt - rs;
                    fnXor:   return rs ^ rt;
                    default: return rs & ~rt;
                endcase
            end
            opSeq:    return {15'b0, diff == '0};
            opSlt:    return {15'b0, diff[15]};
            opSle:    return {15'b0, diff[15] | (diff == '0)};
            opSco:    return {15'b0, wide[16]};
            opLbi:    return {{8{ins[7]}}, ins[7:0]};
            opSlbi:   return {rs[7:0], ins[7:0]};
            default:  return '0;
        endcase
    endfunction

    task automatic issue(input instr_t i, input word_t rs, input word_t rt);
        @(negedge clk);
        inValid = 1'b1;
        instr   = i;
        rsData  = rs;
        rtData  = rt;
        expQ.push_back(refResult(i, rs, rt));
        // sampled at the next edge and seen pipeDepth edges later
        dueQ.push_back(cycle + pipeDepth);
    endtask

    // idle inputs carry junk that the pipe must ignore
    task automatic idle();
        @(negedge clk);
        inValid = 1'b0;
        instr   = instr_t'($urandom);
        rsData  = word_t'($urandom);
        rtData  = word_t'($urandom);
    endtask

    task automatic shiftSweep(input shamt_t amt);
        word_t v;
        v = word_t'($urandom);
        issue({opRoli, 6'd0, 1'b0, amt}, v, 16'h0);
        issue({opSlli, 6'd0, 1'b0, amt}, v, 16'h0);
        issue({opRori, 6'd0, 1'b0, amt}, v, 16'h0);
        issue({opSrli, 6'd0, 1'b1, amt}, v, 16'h0);
        issue({opShiftR, 9'd0, shRol}, v, {12'habc, amt});
        issue({opShiftR, 9'd0, shSll}, v, {12'h123, amt});
        issue({opShiftR, 9'd0, shRor}, v, {12'hfff, amt});
        issue({opShiftR, 9'd0, shSrl}, v, {12'h800, amt});
    endtask

    task automatic compareSweep(input opcode_t op);
        issue({op, 11'd0}, 16'h1234, 16'h1234);
        issue({op, 11'd0}, 16'h8000, 16'h7fff);
        issue({op, 11'd0}, 16'h7fff, 16'h8000);
        issue({op, 11'd0}, 16'hffff, 16'h0001);
    endtask

    task automatic directed();
        // signed imm5 at -16 and +15
        issue({opAddi, 6'd0, 5'h10}, 16'h1234, 16'h0);
        issue({opAddi, 6'd0, 5'h0f}, 16'hfff8, 16'h0);
        issue({opSubi, 6'd0, 5'h10}, 16'h0005, 16'h0);
        issue({opSubi, 6'd0, 5'h0f}, 16'h8000, 16'h0);
        issue({opArithR, 9'd0, fnAdd}, 16'h7fff, 16'h0001);
        issue({opArithR, 9'd0, fnSub}, 16'h0003, 16'h0001);
        issue({opLd, 6'd0, 5'h1f}, 16'h0100, 16'h0);
        issue({opSt, 6'd0, 5'h07}, 16'hfffe, 16'h0);
        issue({opStu, 6'd0, 5'h10}, 16'h0010, 16'h0);
        issue({opXori, 6'd0, 5'h1f}, 16'ha5a5, 16'h0);
        issue({opAndni, 6'd0, 5'h15}, 16'hffff, 16'h0);
        issue({opArithR, 9'd0, fnXor}, 16'hf0f0, 16'h3c3c);
        issue({opArithR, 9'd0, fnAndn}, 16'hf0f0, 16'h3c3c);
        shiftSweep(4'd0);
        shiftSweep(4'd1);
        shiftSweep(4'd15);
        shiftSweep(shamt_t'($urandom));
        issue({opBtr, 11'd0}, 16'h8001, 16'h0);
        issue({opBtr, 11'd0}, 16'h1234, 16'h0);
        compareSweep(opSeq);
        compareSweep(opSlt);
        compareSweep(opSle);
        compareSweep(opSco);
        issue({opLbi, 3'd0, 8'h80}, 16'h0, 16'h0);
        issue({opLbi, 3'd0, 8'h7f}, 16'h0, 16'h0);
        issue({opSlbi, 3'd0, 8'h3c}, 16'h12ab, 16'h0);
        // unused opcodes
        issue({5'b00000, 11'h7ff}, 16'hffff, 16'hffff);
        issue({5'b00111, 11'h123}, 16'h1111, 16'h2222);
        issue({5'b01100, 11'h456}, 16'h3333, 16'h4444);
        issue({5'b01111, 11'h789}, 16'h5555, 16'h6666);
    endtask

    task automatic randomRun();
        for (int n = 0; n < numRandom; n++) begin
            if ($urandom % 4 == 0) begin
                idle();
            end
            pick = 5'($urandom % 20);
            issue({opTable[pick], 11'($urandom)}, word_t'($urandom), word_t'($urandom));
        end
    endtask

    initial begin
        void'($urandom(32'h7e32));
        rstN    = 1'b0;
        inValid = 1'b0;
        instr   = '0;
        rsData  = '0;
        rtData  = '0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        directed();
        repeat (3) idle();
        randomRun();
        idle();
        repeat (pipeDepth + 4) @(negedge clk);
        if (expQ.size() != 0) begin
            protoErrs++;
            $display("%0d results never came out of the pipeline", expQ.size());
        end
        $display("checked %0d results: %0d value errors, %0d latency errors, %0d protocol errors",
                 checked, valueErrs, timingErrs, protoErrs);
        if (valueErrs + timingErrs + protoErrs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    always @(negedge clk) begin
        if (!rstN) begin
            if (cycle > 0 && outValid !== 1'b0) begin
                protoErrs++;
                $display("outValid is not low during reset at cycle %0d", cycle);
            end
        end else if (outValid === 1'b1) begin
            if (expQ.size() == 0) begin
                protoErrs++;
                $display("outValid high at cycle %0d with nothing outstanding", cycle);
            end else begin
                expVal   = expQ.pop_front();
                dueCycle = dueQ.pop_front();
                checked++;
                if (result !== expVal) begin
                    valueErrs++;
                    $display("ERR result: expected %h, got %h (result %0d)",
                             expVal, result, checked);
                end
                if (cycle != dueCycle) begin
                    timingErrs++;
                    $display("result %0d came out at cycle %0d instead of cycle %0d",
                             checked, cycle, dueCycle);
                end
            end
        end
    end

    initial begin
        #(timeoutNs);
        $display("watchdog expired after %0d ns with the run unfinished", timeoutNs);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== sim.f ====
hdl/isaPkg.sv
hdl/aluPkg.sv
hdl/instrDecode.sv
hdl/operandSelect.sv
hdl/shiftUnit.sv
hdl/aluExecute.sv
hdl/executePipe.sv
test/executePipe_props.sv
test/executePipeTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the execute pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module executePipeTb \
    --Mdir obj_dir \
    -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/VexecutePipeTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1
